// File: src.f
verilog/cpuPkg.sv
verilog/registerFile.sv
verilog/aluStage.sv
verilog/decimalAdjust.sv
verilog/statusReg.sv
verilog/dataPath6502.sv
tb/tbClock.sv
tb/dataPath6502_properties.sv
tb/dataPath6502_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the datapath testbench with Verilator, run it, and grep the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module dataPath6502_tb -Mdir obj_dir -f src.f \
    && ./obj_dir/VdataPath6502_tb > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/dataPath6502_tb.sv
// directed tests for the 6502 datapath: reset, binary and BCD arithmetic,
// logic and shift ops, status strobes and halt, with compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none

module dataPath6502_tb;

    import cpuPkg::*;

    // rough cycle cost of each test
    localparam int resetCycles   = 10;
    localparam int randomOps     = 8;
    localparam int binaryCycles  = randomOps * 14 + 3;
    localparam int logicCycles   = 34;
    localparam int decimalCycles = 36;
    localparam int statusCycles  = 26;
    localparam int haltCycles    = 20;
    localparam int cycleLimit    = 2 * (resetCycles + binaryCycles + logicCycles
                                        + decimalCycles + statusCycles + haltCycles);

    logic      phi2;
    logic      rstAll;
    logic      haltAll;
    logic      issue;
    aluOpT     aluOp;
    regSelT    srcSel;
    logic      bInvert;
    regSelT    dstSel;
    flagClassT flagClass;
    byteT      dataIn;
    logic      cSet;
    logic      cClr;
    logic      iSet;
    logic      iClr;
    logic      dSet;
    logic      dClr;
    logic      vClr;
    logic      pLoad;
    byteT      acc;
    byteT      xReg;
    byteT      yReg;
    byteT      status;

    int   seed;
    int   errorCount;
    int   testsRun;
    int   testsFailed;
    int   cycleCount = 0;
    // status the DUT should show now
    byteT expStatus;

    tbClock clockGen (.phi2(phi2));

    dataPath6502 #(.hasDecimal(1'b1)) uut (
        .phi2(phi2), .rstAll(rstAll), .haltAll(haltAll), .issue(issue),
        .aluOp(aluOp), .srcSel(srcSel), .bInvert(bInvert), .dstSel(dstSel),
        .flagClass(flagClass), .dataIn(dataIn),
        .cSet(cSet), .cClr(cClr), .iSet(iSet), .iClr(iClr),
        .dSet(dSet), .dClr(dClr), .vClr(vClr), .pLoad(pLoad),
        .acc(acc), .xReg(xReg), .yReg(yReg), .status(status)
    );

    function automatic byteT randomByte();
        int draw;
        draw = $random(seed);
        return draw[7:0];
    endfunction

    // two's complement value of a byte
    function automatic int toSigned(byteT value);
        return value[7] ? int'(value) - 256 : int'(value);
    endfunction

    // {carry, overflow, result} of a + b + cin
    function automatic logic [9:0] binaryAdd(byteT a, byteT b, logic cin);
        int total;
        int signedTotal;
        total = int'(a) + int'(b) + int'(cin);
        signedTotal = toSigned(a) + toSigned(b) + int'(cin);
        return {total > 255, (signedTotal > 127) || (signedTotal < -128), total[7:0]};
    endfunction

    // {carry, overflow, result} of a - b with carry as not borrow
    function automatic logic [9:0] binarySub(byteT a, byteT b, logic cin);
        int diff;
        int signedDiff;
        diff = int'(a) - int'(b) - int'(!cin);
        signedDiff = toSigned(a) - toSigned(b) - int'(!cin);
        return {diff >= 0, (signedDiff > 127) || (signedDiff < -128), diff[7:0]};
    endfunction

    // N from bit 7, Z on a zero result
    function automatic byteT withNz(byteT p, byteT result);
        byteT updated;
        updated = p;
        updated[statusN] = result[7];
        updated[statusZ] = (result == 8'h00);
        return updated;
    endfunction

    task automatic checkByte(input string name, input byteT expected, input byteT actual);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkStatus(input byteT expected, input byteT actual);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED status expected %h actual %h", expected, actual);
        end
    endtask

    task automatic reportTest(input string name, input int errorsAtStart);
        testsRun++;
        if (errorCount == errorsAtStart) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d check(s) failed", name, errorCount - errorsAtStart);
        end
    endtask

    // one-cycle issue strobe with its operation fields
    task automatic driveIssue(input aluOpT op, input regSelT src, input logic inv,
                              input regSelT dst, input flagClassT cls, input byteT data);
        @(posedge phi2);
        issue     <= 1'b1;
        aluOp     <= op;
        srcSel    <= src;
        bInvert   <= inv;
        dstSel    <= dst;
        flagClass <= cls;
        dataIn    <= data;
    endtask

    // issue, then wait out the two-edge latency and settle at the falling edge
    task automatic runOp(input aluOpT op, input regSelT src, input logic inv,
                         input regSelT dst, input flagClassT cls, input byteT data);
        driveIssue(op, src, inv, dst, cls, data);
        @(posedge phi2);
        issue   <= 1'b0;
        bInvert <= 1'b0;
        @(posedge phi2);
        @(negedge phi2);
    endtask

    // strobes take effect at the first edge and set beats clear
    task automatic pulseStrobes(input logic cs, input logic cc, input logic is,
                                input logic ic, input logic ds, input logic dc,
                                input logic vc);
        @(posedge phi2);
        cSet <= cs;
        cClr <= cc;
        iSet <= is;
        iClr <= ic;
        dSet <= ds;
        dClr <= dc;
        vClr <= vc;
        @(posedge phi2);
        cSet <= 1'b0;
        cClr <= 1'b0;
        iSet <= 1'b0;
        iClr <= 1'b0;
        dSet <= 1'b0;
        dClr <= 1'b0;
        vClr <= 1'b0;
        @(negedge phi2);
        if (cc) expStatus[statusC] = 1'b0;
        if (cs) expStatus[statusC] = 1'b1;
        if (ic) expStatus[statusI] = 1'b0;
        if (is) expStatus[statusI] = 1'b1;
        if (dc) expStatus[statusD] = 1'b0;
        if (ds) expStatus[statusD] = 1'b1;
        if (vc) expStatus[statusV] = 1'b0;
        checkStatus(expStatus, status);
    endtask

    task automatic loadStatus(input byteT value, input byteT expected);
        @(posedge phi2);
        pLoad  <= 1'b1;
        dataIn <= value;
        @(posedge phi2);
        pLoad  <= 1'b0;
        @(negedge phi2);
        expStatus = expected;
        checkStatus(expStatus, status);
    endtask

    // accumulator load as OR from the zero source
    task automatic loadAcc(input byteT value);
        runOp(opOr, selNone, 1'b0, selAcc, flagNz, value);
        expStatus = withNz(expStatus, value);
        checkByte("acc", value, acc);
        checkStatus(expStatus, status);
    endtask

    task automatic testReset();
        int startErrors;
        startErrors = errorCount;
        @(negedge phi2);
        checkByte("acc", 8'h00, acc);
        checkByte("xReg", 8'h00, xReg);
        checkByte("yReg", 8'h00, yReg);
        checkStatus(statusReset, status);
        reportTest("reset", startErrors);
    endtask

    task automatic testBinary();
        int startErrors;
        byteT a;
        byteT b;
        byteT x;
        logic [9:0] expected;
        startErrors = errorCount;
        for (int i = 0; i < randomOps; i++) begin
            a = randomByte();
            b = randomByte();
            // add with whatever carry is left over
            loadAcc(a);
            expected = binaryAdd(a, b, expStatus[statusC]);
            runOp(opSum, selAcc, 1'b0, selAcc, flagNzcv, b);
            expStatus = withNz(expStatus, expected[7:0]);
            expStatus[statusV] = expected[8];
            expStatus[statusC] = expected[9];
            checkByte("acc", expected[7:0], acc);
            checkStatus(expStatus, status);
            // subtract with no borrow
            loadAcc(a);
            pulseStrobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            expected = binarySub(a, b, 1'b1);
            runOp(opSum, selAcc, 1'b1, selAcc, flagNzcv, b);
            expStatus = withNz(expStatus, expected[7:0]);
            expStatus[statusV] = expected[8];
            expStatus[statusC] = expected[9];
            checkByte("acc", expected[7:0], acc);
            checkStatus(expStatus, status);
        end
        // transfer into X leaves C and V alone
        x = randomByte();
        a = expected[7:0];
        runOp(opOr, selNone, 1'b0, selX, flagNz, x);
        expStatus = withNz(expStatus, x);
        checkByte("xReg", x, xReg);
        checkByte("acc", a, acc);
        checkStatus(expStatus, status);
        reportTest("binary", startErrors);
    endtask

    task automatic testLogic();
        int startErrors;
        byteT a;
        byteT b;
        byteT expected;
        startErrors = errorCount;
        a = randomByte();
        loadAcc(a);
        b = randomByte();
        expected = a & b;
        runOp(opAnd, selAcc, 1'b0, selAcc, flagNz, b);
        expStatus = withNz(expStatus, expected);
        checkByte("acc", expected, acc);
        checkStatus(expStatus, status);
        b = randomByte();
        expected = expected ^ b;
        runOp(opEor, selAcc, 1'b0, selAcc, flagNz, b);
        expStatus = withNz(expStatus, expected);
        checkByte("acc", expected, acc);
        checkStatus(expStatus, status);
        b = randomByte();
        expected = expected | b;
        runOp(opOr, selAcc, 1'b0, selAcc, flagNz, b);
        expStatus = withNz(expStatus, expected);
        checkByte("acc", expected, acc);
        checkStatus(expStatus, status);
        // shift right moves old C into bit 7 and bit 0 out to C
        for (int i = 0; i < 2; i++) begin
            pulseStrobes(i == 0, i != 0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            b = randomByte();
            expected = {expStatus[statusC], b[7:1]};
            runOp(opShr, selNone, 1'b0, selAcc, flagNzc, b);
            expStatus = withNz(expStatus, expected);
            expStatus[statusC] = b[0];
            checkByte("acc", expected, acc);
            checkStatus(expStatus, status);
        end
        reportTest("logic", startErrors);
    endtask

    // one BCD case with the expected digits worked out by hand
    task automatic decimalCase(input byteT a, input byteT b, input logic sub,
                               input byteT expResult, input logic expCarry);
        logic [9:0] binary;
        pulseStrobes(sub, !sub, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        loadAcc(a);
        // V comes from the binary sum
        binary = sub ? binarySub(a, b, 1'b1) : binaryAdd(a, b, 1'b0);
        runOp(opSum, selAcc, sub, selAcc, flagNzcv, b);
        expStatus = withNz(expStatus, expResult);
        expStatus[statusV] = binary[8];
        expStatus[statusC] = expCarry;
        checkByte("acc", expResult, acc);
        checkStatus(expStatus, status);
    endtask

    task automatic testDecimal();
        int startErrors;
        startErrors = errorCount;
        pulseStrobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        decimalCase(8'h19, 8'h28, 1'b0, 8'h47, 1'b0);
        decimalCase(8'h58, 8'h46, 1'b0, 8'h04, 1'b1);
        decimalCase(8'h99, 8'h01, 1'b0, 8'h00, 1'b1);
        decimalCase(8'h50, 8'h21, 1'b1, 8'h29, 1'b1);
        pulseStrobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        reportTest("decimal", startErrors);
    endtask

    task automatic testStatus();
        int startErrors;
        startErrors = errorCount;
        // B reads 0 and bit 5 reads 1
        loadStatus(8'hFF, 8'hEF);
        pulseStrobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        pulseStrobes(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        pulseStrobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        pulseStrobes(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        pulseStrobes(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        pulseStrobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        pulseStrobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        // both C strobes at once
        pulseStrobes(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        loadStatus(8'h00, 8'h20);
        reportTest("status", startErrors);
    endtask

    task automatic testHalt();
        int startErrors;
        byteT oldAcc;
        byteT oldY;
        byteT value;
        startErrors = errorCount;
        // known accumulator with N clear
        oldAcc = randomByte() & 8'h7F;
        // Y still at its reset value
        oldY = 8'h00;
        loadAcc(oldAcc);
        // issue while frozen is dropped
        @(posedge phi2);
        haltAll <= 1'b1;
        runOp(opOr, selNone, 1'b0, selAcc, flagNz, ~oldAcc);
        checkByte("acc", oldAcc, acc);
        checkStatus(expStatus, status);
        @(posedge phi2);
        haltAll <= 1'b0;
        repeat (2) @(posedge phi2);
        @(negedge phi2);
        checkByte("acc", oldAcc, acc);
        checkStatus(expStatus, status);
        // op caught in the hold stage
        // N set so its flag update shows
        value = randomByte() | 8'h81;
        driveIssue(opOr, selNone, 1'b0, selY, flagNz, value);
        @(posedge phi2);
        issue   <= 1'b0;
        haltAll <= 1'b1;
        repeat (3) @(posedge phi2);
        @(negedge phi2);
        checkByte("yReg", oldY, yReg);
        checkStatus(expStatus, status);
        @(posedge phi2);
        haltAll <= 1'b0;
        @(posedge phi2);
        @(negedge phi2);
        expStatus = withNz(expStatus, value);
        checkByte("yReg", value, yReg);
        checkStatus(expStatus, status);
        reportTest("halt", startErrors);
    endtask

    // run limit
    always @(posedge phi2) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: tests still running after %0d cycles", cycleCount);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        seed        = 72493;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        expStatus   = statusReset;
        rstAll    <= 1'b1;
        haltAll   <= 1'b0;
        issue     <= 1'b0;
        aluOp     <= opSum;
        srcSel    <= selNone;
        bInvert   <= 1'b0;
        dstSel    <= selNone;
        flagClass <= flagNone;
        dataIn    <= '0;
        cSet      <= 1'b0;
        cClr      <= 1'b0;
        iSet      <= 1'b0;
        iClr      <= 1'b0;
        dSet      <= 1'b0;
        dClr      <= 1'b0;
        vClr      <= 1'b0;
        pLoad     <= 1'b0;
        repeat (8) @(posedge phi2);
        rstAll <= 1'b0;
        testReset();
        testBinary();
        testLogic();
        testDecimal();
        testStatus();
        testHalt();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/dataPath6502_properties.sv
// bound assertions for the datapath top: reset value,
// halt freeze and the fixed status bits
`timescale 1ns/1ps
`default_nettype none

module dataPath6502_properties (
    input wire               phi2,
    input wire               rstAll,
    input wire               haltAll,
    input wire cpuPkg::byteT acc,
    input wire cpuPkg::byteT xReg,
    input wire cpuPkg::byteT yReg,
    input wire cpuPkg::byteT status
);

    import cpuPkg::*;

    // reset edge loads 20 into status
    statusAfterReset: assert property (@(posedge phi2) rstAll |=> (status == statusReset))
        else $error("status differs from its reset value in the cycle after rstAll");

    // frozen edge, nothing moves
    haltFreeze: assert property (@(posedge phi2) (haltAll && !rstAll) |=>
        ($stable(acc) && $stable(xReg) && $stable(yReg) && $stable(status)))
        else $error("a register changed across a cycle with haltAll high");

    // bit 5 tied high, no B flag in bit 4
    fixedBits: assert property (@(posedge phi2) (status[5] && !status[4]))
        else $error("status bit 5 or bit 4 left its fixed value");

endmodule

bind dataPath6502 dataPath6502_properties props (
    .phi2(phi2), .rstAll(rstAll), .haltAll(haltAll),
    .acc(acc), .xReg(xReg), .yReg(yReg), .status(status)
);

`default_nettype wire

// File: tb/tbClock.sv
// phi2 clock source for the testbench, 8 ns period
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int halfPeriod = 4
) (
    output logic phi2
);

    // start low so the first rising edge lands at 4 ns
    initial begin
        phi2 = 1'b0;
    end

    always begin
        #halfPeriod phi2 = ~phi2;
    end

endmodule

`default_nettype wire

// File: verilog/dataPath6502.sv
// 6502 arithmetic datapath top: register file, ALU hold stage,
// decimal adjust and status register
`timescale 1ns/1ps
`default_nettype none

module dataPath6502 #(
    parameter bit hasDecimal = 1'b1
) (
    input  wire                    phi2,
    input  wire                    rstAll,
    input  wire                    haltAll,
    input  wire                    issue,
    input  wire cpuPkg::aluOpT     aluOp,
    input  wire cpuPkg::regSelT    srcSel,
    input  wire                    bInvert,
    input  wire cpuPkg::regSelT    dstSel,
    input  wire cpuPkg::flagClassT flagClass,
    input  wire cpuPkg::byteT      dataIn,
    input  wire                    cSet,
    input  wire                    cClr,
    input  wire                    iSet,
    input  wire                    iClr,
    input  wire                    dSet,
    input  wire                    dClr,
    input  wire                    vClr,
    input  wire                    pLoad,
    output cpuPkg::byteT           acc,
    output cpuPkg::byteT           xReg,
    output cpuPkg::byteT           yReg,
    output cpuPkg::byteT           status
);

    import cpuPkg::*;

    // issue side
    wire byteT      operandA;
    wire            carryFlag;
    wire            decimalFlag;
    // hold stage outputs
    wire byteT      heldResult;
    wire            heldCarry;
    wire            heldOverflow;
    wire            heldHalfCarry;
    wire            heldValid;
    wire decModeT   heldDecMode;
    wire regSelT    heldDst;
    wire flagClassT heldFlagClass;
    // after BCD correction
    wire byteT      finalResult;
    wire            finalCarry;

    registerFile regs (
        .phi2(phi2), .rstAll(rstAll), .haltAll(haltAll),
        .srcSel(srcSel), .dstSel(heldDst), .writeEn(heldValid),
        .writeData(finalResult), .operandA(operandA),
        .acc(acc), .xReg(xReg), .yReg(yReg)
    );

    aluStage #(.hasDecimal(hasDecimal)) alu (
        .phi2(phi2), .rstAll(rstAll), .haltAll(haltAll), .issue(issue),
        .aluOp(aluOp), .operandA(operandA), .dataIn(dataIn), .bInvert(bInvert),
        .carryFlag(carryFlag), .decimalFlag(decimalFlag),
        .dstSel(dstSel), .flagClass(flagClass),
        .heldResult(heldResult), .heldCarry(heldCarry),
        .heldOverflow(heldOverflow), .heldHalfCarry(heldHalfCarry),
        .heldValid(heldValid), .heldDecMode(heldDecMode),
        .heldDst(heldDst), .heldFlagClass(heldFlagClass)
    );

    decimalAdjust bcd (
        .heldResult(heldResult), .heldCarry(heldCarry),
        .heldHalfCarry(heldHalfCarry), .heldDecMode(heldDecMode),
        .finalResult(finalResult), .finalCarry(finalCarry)
    );

    statusReg flags (
        .phi2(phi2), .rstAll(rstAll), .haltAll(haltAll),
        .heldValid(heldValid), .heldFlagClass(heldFlagClass),
        .finalResult(finalResult), .finalCarry(finalCarry),
        .heldOverflow(heldOverflow), .pLoad(pLoad), .dataIn(dataIn),
        .cSet(cSet), .cClr(cClr), .iSet(iSet), .iClr(iClr),
        .dSet(dSet), .dClr(dClr), .vClr(vClr),
        .status(status), .carryFlag(carryFlag), .decimalFlag(decimalFlag)
    );

endmodule

`default_nettype wire

// File: verilog/statusReg.sv
// NV-BDIZC status register
// class-based flag updates, set/clear strobes and full byte load
`timescale 1ns/1ps
`default_nettype none

module statusReg (
    input  wire                    phi2,
    input  wire                    rstAll,
    input  wire                    haltAll,
    input  wire                    heldValid,
    input  wire cpuPkg::flagClassT heldFlagClass,
    input  wire cpuPkg::byteT      finalResult,
    input  wire                    finalCarry,
    input  wire                    heldOverflow,
    input  wire                    pLoad,
    input  wire cpuPkg::byteT      dataIn,
    input  wire                    cSet,
    input  wire                    cClr,
    input  wire                    iSet,
    input  wire                    iClr,
    input  wire                    dSet,
    input  wire                    dClr,
    input  wire                    vClr,
    output cpuPkg::byteT           status,
    output logic                   carryFlag,
    output logic                   decimalFlag
);

    import cpuPkg::*;

    logic nFlag, vFlag, dFlag, iFlag, zFlag, cFlag;
    logic nNext, vNext, dNext, iNext, zNext, cNext;
    logic resultZero;

    assign resultZero = (finalResult == '0);

    // lowest priority first, later assignments win
    always_comb begin
        nNext = nFlag;
        vNext = vFlag;
        dNext = dFlag;
        iNext = iFlag;
        zNext = zFlag;
        cNext = cFlag;
        // strobes, set beats clear
        if (cClr) cNext = 1'b0;
        if (cSet) cNext = 1'b1;
        if (iClr) iNext = 1'b0;
        if (iSet) iNext = 1'b1;
        if (dClr) dNext = 1'b0;
        if (dSet) dNext = 1'b1;
        if (vClr) vNext = 1'b0;
        // stage-2 result flags
        if (heldValid && heldFlagClass != flagNone) begin
            nNext = finalResult[7];
            zNext = resultZero;
            if (heldFlagClass == flagNzcv || heldFlagClass == flagNzc) begin
                cNext = finalCarry;
            end
            if (heldFlagClass == flagNzcv) begin
                vNext = heldOverflow;
            end
        end
        // whole byte from the data input
        if (pLoad) begin
            nNext = dataIn[statusN];
            vNext = dataIn[statusV];
            dNext = dataIn[statusD];
            iNext = dataIn[statusI];
            zNext = dataIn[statusZ];
            cNext = dataIn[statusC];
        end
    end

    always_ff @(posedge phi2) begin
        if (rstAll) begin
            nFlag <= statusReset[statusN];
            vFlag <= statusReset[statusV];
            dFlag <= statusReset[statusD];
            iFlag <= statusReset[statusI];
            zFlag <= statusReset[statusZ];
            cFlag <= statusReset[statusC];
        end else if (!haltAll) begin
            nFlag <= nNext;
            vFlag <= vNext;
            dFlag <= dNext;
            iFlag <= iNext;
            zFlag <= zNext;
            cFlag <= cNext;
        end
    end

    // bit 5 fixed high, B not modelled so bit 4 low
    always_comb begin
        status          = statusReset;
        status[statusN] = nFlag;
        status[statusV] = vFlag;
        status[statusD] = dFlag;
        status[statusI] = iFlag;
        status[statusZ] = zFlag;
        status[statusC] = cFlag;
    end

    // read by the ALU at issue
    assign carryFlag   = cFlag;
    assign decimalFlag = dFlag;

endmodule

`default_nettype wire

// File: verilog/decimalAdjust.sv
// BCD correction of the held sum and the decimal carry
`timescale 1ns/1ps
`default_nettype none

module decimalAdjust (
    input  wire cpuPkg::byteT    heldResult,
    input  wire                  heldCarry,
    input  wire                  heldHalfCarry,
    input  wire cpuPkg::decModeT heldDecMode,
    output cpuPkg::byteT         finalResult,
    output logic                 finalCarry
);

    import cpuPkg::*;

    always_comb begin
        // binary pass-through by default
        finalResult = heldResult;
        finalCarry  = heldCarry;
        case (heldDecMode)
            decAdd: begin
                // low digit out of range or carried
                if (heldResult[3:0] > 4'd9 || heldHalfCarry) begin
                    finalResult = finalResult + 8'h06;
                end
                // high digit test uses the binary sum, not the corrected one
                if (heldCarry || heldResult > 8'h99) begin
                    finalResult = finalResult + 8'h60;
                    finalCarry  = 1'b1;
                end
            end
            decSub: begin
                // borrow out of the low digit
                if (!heldHalfCarry) begin
                    finalResult = finalResult - 8'h06;
                end
                // borrow out of the high digit, carry passes through
                if (!heldCarry) begin
                    finalResult = finalResult - 8'h60;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/aluStage.sv
// operand B inversion, ALU and the adder hold register
// with latched flags and writeback control
`timescale 1ns/1ps
`default_nettype none

module aluStage #(
    parameter bit hasDecimal = 1'b1
) (
    input  wire                    phi2,
    input  wire                    rstAll,
    input  wire                    haltAll,
    input  wire                    issue,
    input  wire cpuPkg::aluOpT     aluOp,
    input  wire cpuPkg::byteT      operandA,
    input  wire cpuPkg::byteT      dataIn,
    input  wire                    bInvert,
    input  wire                    carryFlag,
    input  wire                    decimalFlag,
    input  wire cpuPkg::regSelT    dstSel,
    input  wire cpuPkg::flagClassT flagClass,
    output cpuPkg::byteT           heldResult,
    output logic                   heldCarry,
    output logic                   heldOverflow,
    output logic                   heldHalfCarry,
    output logic                   heldValid,
    output cpuPkg::decModeT        heldDecMode,
    output cpuPkg::regSelT         heldDst,
    output cpuPkg::flagClassT      heldFlagClass
);

    import cpuPkg::*;

    byteT             operandB;
    logic [dataWidth:0] sumFull;
    logic [4:0]       halfSum;
    byteT             aluResult;
    logic             aluCarry;
    logic             aluOverflow;
    decModeT          decMode;

    // subtract path feeds ~B, carry acts as not borrow
    assign operandB = bInvert ? ~dataIn : dataIn;

    // 9-bit sum, top bit is the carry out
    assign sumFull = {1'b0, operandA} + {1'b0, operandB} + {{dataWidth{1'b0}}, carryFlag};
    // carry out of bit 3, carry in included
    assign halfSum = {1'b0, operandA[3:0]} + {1'b0, operandB[3:0]} + {4'b0, carryFlag};

    always_comb begin
        aluCarry    = 1'b0;
        aluOverflow = 1'b0;
        case (aluOp)
            opSum: begin
                aluResult   = sumFull[dataWidth-1:0];
                aluCarry    = sumFull[dataWidth];
                // same input signs, different result sign
                aluOverflow = (operandA[7] == operandB[7]) && (sumFull[7] != operandA[7]);
            end
            opAnd:   aluResult = operandA & operandB;
            opEor:   aluResult = operandA ^ operandB;
            opOr:    aluResult = operandA | operandB;
            opShr: begin
                aluResult = {carryFlag, operandB[7:1]};
                aluCarry  = operandB[0];
            end
            default: aluResult = '0;
        endcase
    end

    // decimal correction chosen at issue from the D flag
    always_comb begin
        if (hasDecimal && decimalFlag && aluOp == opSum) begin
            decMode = bInvert ? decSub : decAdd;
        end else begin
            decMode = decOff;
        end
    end

    // control half of the hold stage
    always_ff @(posedge phi2) begin
        if (rstAll) begin
            heldValid     <= 1'b0;
            heldDecMode   <= decOff;
            heldDst       <= selNone;
            heldFlagClass <= flagNone;
        end else if (!haltAll) begin
            // idle cycle leaves a bubble
            heldValid <= issue;
            if (issue) begin
                heldDecMode   <= decMode;
                heldDst       <= dstSel;
                heldFlagClass <= flagClass;
            end
        end
    end

    // payload half, only loaded on issue
    always_ff @(posedge phi2) begin
        if (!haltAll && issue) begin
            heldResult    <= aluResult;
            heldCarry     <= aluCarry;
            heldOverflow  <= aluOverflow;
            heldHalfCarry <= halfSum[4];
        end
    end

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
// accumulator and X/Y index registers
// with the A operand source select
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire                 phi2,
    input  wire                 rstAll,
    input  wire                 haltAll,
    input  wire cpuPkg::regSelT srcSel,
    input  wire cpuPkg::regSelT dstSel,
    input  wire                 writeEn,
    input  wire cpuPkg::byteT   writeData,
    output cpuPkg::byteT        operandA,
    output cpuPkg::byteT        acc,
    output cpuPkg::byteT        xReg,
    output cpuPkg::byteT        yReg
);

    import cpuPkg::*;

    // writeback from the decimal adjust output
    always_ff @(posedge phi2) begin
        if (rstAll) begin
            acc  <= '0;
            xReg <= '0;
            yReg <= '0;
        end else if (!haltAll && writeEn) begin
            case (dstSel)
                selAcc:  acc  <= writeData;
                selX:    xReg <= writeData;
                selY:    yReg <= writeData;
                // selNone discards the result
                default: ;
            endcase
        end
    end

    // operand A select by source register
    always_comb begin
        case (srcSel)
            selAcc:  operandA = acc;
            selX:    operandA = xReg;
            selY:    operandA = yReg;
            // zero source lets a load be done as OR with data
            default: operandA = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/cpuPkg.sv
// shared datapath types: byte width, ALU opcodes, register selects,
// flag classes, decimal modes and the status bit layout
`default_nettype none

package cpuPkg;

    // datapath width
    localparam int dataWidth = 8;

    typedef logic [dataWidth-1:0] byteT;

    // ALU operations
    typedef enum logic [2:0] {
        opSum,   // A + B + carry in
        opAnd,
        opEor,
        opOr,
        opShr    // carry in to bit 7, bit 0 out as carry
    } aluOpT;

    // register names, selNone reads zero and writes nowhere
    typedef enum logic [1:0] {
        selNone,
        selAcc,
        selX,
        selY
    } regSelT;

    // which flags a result updates
    typedef enum logic [1:0] {
        flagNone,
        flagNzcv,   // add and subtract
        flagNz,     // logic ops, transfers
        flagNzc     // shifts
    } flagClassT;

    // BCD correction applied to the held sum
    typedef enum logic [1:0] {
        decOff,
        decAdd,
        decSub
    } decModeT;

    // NV-BDIZC bit positions
    localparam int statusN = 7;
    localparam int statusV = 6;
    localparam int statusD = 3;
    localparam int statusI = 2;
    localparam int statusZ = 1;
    localparam int statusC = 0;

    // only the unused bit 5 set
    localparam byteT statusReset = 8'h20;

endpackage

`default_nettype wire
